// File: bp_top.f
+incdir+include
verilog/bp_pkg.sv
verilog/bp_request_stage.sv
verilog/pattern_table.sv
verilog/predictor_scoreboard.sv
verilog/prediction_arbiter.sv
verilog/bp_result_stage.sv
verilog/bp_top.sv
tests/tb_clock_gen.sv
tests/tb_bp_top.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the branch predictor testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f bp_top.f --top-module tb_bp_top -Mdir obj_dir -o sim_bp
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/sim_bp > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" sim.log; then
  exit 1
fi
if ! grep -q "all tests passed" sim.log; then
  echo "no result line found in sim.log"
  exit 1
fi
exit 0

// File: tests/tb_bp_top.sv
`timescale 1ns/1ns

module tb_bp_top;

  localparam int CYCLE_BUDGET = 700;

  logic                clk;
  logic                rst_n;
  logic                lookup_valid;
  bp_pkg::pc_t         lookup_pc;
  logic                lookup_backward;
  logic                update_valid;
  bp_pkg::pc_t         update_pc;
  logic                update_backward;
  logic                update_taken;
  logic                pred_valid;
  logic                pred_taken;
  bp_pkg::miss_count_t miss_count;

  int          errors = 0;
  int          checks = 0;
  int          pulses = 0;
  string       test_name = "reset";
  logic [31:0] lfsr = 32'h2357fc35;

  // Reference state, kept as plain integers.
  int          m_lht [16];
  int          m_ght [16];
  int          m_count [3];
  logic [3:0]  m_trend [3];
  logic [3:0]  m_ghr;
  int          m_miss;
  logic        r_lk_v, r_lk_bw, r_up_v, r_up_bw, r_up_t;
  bp_pkg::pc_t r_lk_pc, r_up_pc;
  logic        exp_valid, exp_taken;

  tb_clock_gen i_clk (.clk);

  bp_top i_dut (
    .clk, .rst_n,
    .lookup_valid, .lookup_pc, .lookup_backward,
    .update_valid, .update_pc, .update_backward, .update_taken,
    .pred_valid, .pred_taken, .miss_count
  );

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]}; // Taps 32, 22, 2, 1.
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Tournament choice: unanimous guess, else weighted lone versus pair.
  function automatic logic arbitrate(input logic g0, input logic g1, input logic g2);
    logic g [3];
    int   w [3];
    int   lone;
    int   pair_sum;
    g[0] = g0;
    g[1] = g1;
    g[2] = g2;
    if (g0 == g1 && g1 == g2) return g0;
    lone = (g0 != g1 && g0 != g2) ? 0 : (g1 != g0) ? 1 : 2;
    pair_sum = 0;
    for (int i = 0; i < 3; i++) begin
      w[i] = m_trend[i][0] ? 0 : m_count[i];
      if (i != lone) pair_sum += w[i];
    end
    if (w[lone] > pair_sum) return g[lone];
    if (w[lone] == pair_sum && m_trend[lone][3:2] == 2'b00) return g[lone];
    return !g[lone];
  endfunction

  // Reference model, stepped on the same edge that the DUT samples.
  always @(posedge clk) begin
    logic       gl, gg, res;
    logic       hit [3];
    logic [3:0] li, gi;
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        m_lht[i] = 1;
        m_ght[i] = 1;
      end
      for (int i = 0; i < 3; i++) begin
        m_count[i] = 0;
        m_trend[i] = '0;
      end
      m_ghr = '0;
      m_miss = 0;
      r_lk_v = 1'b0;
      r_up_v = 1'b0;
      exp_valid = 1'b0;
    end else begin
      exp_valid = r_lk_v;
      if (r_lk_v) begin
        exp_taken = arbitrate(r_lk_bw, m_lht[r_lk_pc[5:2]] >= 2,
                              m_ght[r_lk_pc[5:2] ^ m_ghr] >= 2);
      end
      if (r_up_v) begin
        li = r_up_pc[5:2];
        gi = r_up_pc[5:2] ^ m_ghr;
        gl = m_lht[li] >= 2;
        gg = m_ght[gi] >= 2;
        res = arbitrate(r_up_bw, gl, gg);
        if (res != r_up_t && m_miss < 65535) m_miss++;
        hit[0] = r_up_bw == r_up_t;
        hit[1] = gl == r_up_t;
        hit[2] = gg == r_up_t;
        for (int i = 0; i < 3; i++) begin
          m_trend[i] = {m_trend[i][2:0], !hit[i]};
          if (hit[i] && m_count[i] < 31) m_count[i]++;
          else if (!hit[i] && m_count[i] > 0) m_count[i]--;
        end
        if (r_up_t) begin
          if (m_lht[li] < 3) m_lht[li]++;
          if (m_ght[gi] < 3) m_ght[gi]++;
        end else begin
          if (m_lht[li] > 0) m_lht[li]--;
          if (m_ght[gi] > 0) m_ght[gi]--;
        end
        m_ghr = {m_ghr[2:0], r_up_t};
      end
      r_lk_v = lookup_valid;
      r_lk_pc = lookup_pc;
      r_lk_bw = lookup_backward;
      r_up_v = update_valid;
      r_up_pc = update_pc;
      r_up_bw = update_backward;
      r_up_t = update_taken;
    end
  end

  task automatic check_taken(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s: expected taken=%b, actual taken=%b", name, expected, actual);
    end
  endtask

  task automatic check_miss_count(input string name, input bp_pkg::miss_count_t expected,
                                  input bp_pkg::miss_count_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s: expected miss_count=%0d, actual miss_count=%0d",
               name, expected, actual);
    end
  endtask

  // Outputs are compared away from the sampling edge.
  always @(negedge clk) begin
    if (rst_n) begin
      if (pred_valid !== exp_valid) begin
        errors++;
        $display("In %s the prediction strobe was %b where the 2-cycle latency needs %b",
                 test_name, pred_valid, exp_valid);
      end else if (exp_valid) begin
        check_taken(test_name, exp_taken, pred_taken);
      end
      check_miss_count(test_name, bp_pkg::miss_count_t'(m_miss), miss_count);
      if (pred_valid) pulses++;
    end
  end

  task automatic drive(input logic lv, input bp_pkg::pc_t lpc, input logic lbw,
                       input logic uv, input bp_pkg::pc_t upc, input logic ubw,
                       input logic ut);
    @(posedge clk);
    lookup_valid    <= lv;
    lookup_pc       <= lpc;
    lookup_backward <= lbw;
    update_valid    <= uv;
    update_pc       <= upc;
    update_backward <= ubw;
    update_taken    <= ut;
  endtask

  task automatic idle(input int n);
    repeat (n) drive(0, '0, 0, 0, '0, 0, 0);
  endtask

  task automatic reset_state_test();
    test_name = "reset_state";
    @(negedge clk);
    check_taken("reset_pred_valid", 1'b0, pred_valid);
    check_miss_count("reset_miss_count", '0, miss_count);
    drive(1, 32'h0000_0010, 1, 0, '0, 0, 0);
    idle(2);
    @(negedge clk);
    check_taken("reset_backward_lookup", 1'b1, pred_taken);
    drive(1, 32'h0000_0010, 0, 0, '0, 0, 0);
    idle(2);
    @(negedge clk);
    check_taken("reset_forward_lookup", 1'b0, pred_taken);
  endtask

  task automatic local_training_test();
    test_name = "local_training";
    repeat (2) drive(0, '0, 0, 1, 32'h0000_0024, 0, 1);
    idle(2);
    drive(1, 32'h0000_0024, 0, 0, '0, 0, 0);
    idle(3);
  endtask

  task automatic weighted_test();
    test_name = "weighted_arbitration";
    // The static guess is right on every update, so its hit count climbs past the others.
    for (int i = 0; i < 24; i++) drive(0, '0, 0, 1, 32'h0000_0040, i[0], i[0]);
    idle(2);
    drive(1, 32'h0000_0040, 1, 0, '0, 0, 0);
    drive(0, '0, 0, 1, 32'h0000_0040, 1, 0);
    idle(2);
    // Both tables still read not taken at this entry, so SP stands alone again.
    drive(1, 32'h0000_0004, 1, 0, '0, 0, 0);
    idle(3);
  endtask

  task automatic trend_tie_test();
    test_name = "trend_tie_break";
    drive(0, '0, 0, 1, 32'h0000_0008, 1, 0);
    drive(0, '0, 0, 1, 32'h0000_0008, 1, 1);
    // All three miss here, so every corrected count drops to zero.
    drive(0, '0, 0, 1, 32'h0000_0008, 0, 1);
    idle(2);
    drive(1, 32'h0000_0024, 0, 0, '0, 0, 0); // SP is alone with older misses.
    idle(3);
  endtask

  task automatic latency_order_test();
    int target;
    test_name = "latency_order";
    target = pulses + 4;
    for (int i = 0; i < 4; i++) drive(1, bp_pkg::pc_t'(i * 4), i[0], 0, '0, 0, 0);
    for (int i = 0; i < 8 && pulses < target; i++) idle(1);
    if (pulses != target) begin
      errors++;
      $display("Back-to-back lookups gave %0d prediction pulses instead of 4",
               pulses - target + 4);
    end
    drive(1, 32'h0000_0024, 0, 1, 32'h0000_0024, 0, 0); // Lookup beside an update.
    idle(3);
  endtask

  task automatic random_mix_test();
    logic        lv;
    logic        lbw;
    logic        uv;
    logic        ubw;
    logic        ut;
    bp_pkg::pc_t lpc;
    bp_pkg::pc_t upc;
    test_name = "random_mix";
    for (int i = 0; i < 40; i++) drive(0, '0, 0, 1, 32'h0000_0030, 0, 0);
    for (int i = 0; i < 300; i++) begin
      lv  = 1'(rand_bits(1));
      lpc = rand_bits(6) << 2;
      lbw = 1'(rand_bits(1));
      uv  = 1'(rand_bits(1));
      upc = rand_bits(6) << 2;
      ubw = 1'(rand_bits(1));
      ut  = (rand_bits(2) == 0) ? !ubw : ubw;
      drive(lv, lpc, lbw, uv, upc, ubw, ut);
    end
    idle(3);
  endtask

  initial begin
    rst_n = 1'b0;
    lookup_valid = 1'b0;
    lookup_pc = '0;
    lookup_backward = 1'b0;
    update_valid = 1'b0;
    update_pc = '0;
    update_backward = 1'b0;
    update_taken = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    reset_state_test();
    local_training_test();
    weighted_test();
    trend_tie_test();
    latency_order_test();
    random_mix_test();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(CYCLE_BUDGET * 40 + 4000);
    $display("Watchdog expired before the tests finished");
    $display("tests failed");
    $finish;
  end

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk
);

  initial clk = 1'b0;

  always #20 clk = ~clk; // 40 ns period.

endmodule

// File: verilog/bp_top.sv
`timescale 1ns/1ns
`include "bp_params.svh"

module bp_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                lookup_valid,
  input  bp_pkg::pc_t         lookup_pc,
  input  logic                lookup_backward,
  input  logic                update_valid,
  input  bp_pkg::pc_t         update_pc,
  input  logic                update_backward,
  input  logic                update_taken,
  output logic                pred_valid,
  output logic                pred_taken,
  output bp_pkg::miss_count_t miss_count
);

  logic                 lk_valid;
  bp_pkg::pc_t          lk_pc;
  logic                 lk_backward;
  logic                 up_valid;
  bp_pkg::pc_t          up_pc;
  logic                 up_backward;
  logic                 up_taken;
  bp_pkg::table_index_t ghr;
  bp_pkg::table_index_t lk_local_index;
  bp_pkg::table_index_t lk_global_index;
  bp_pkg::table_index_t up_local_index;
  bp_pkg::table_index_t up_global_index;
  logic                 lhp_lookup;
  logic                 lhp_update;
  logic                 ghp_lookup;
  logic                 ghp_update;
  bp_pkg::trend_t       sp_trend;
  bp_pkg::trend_t       lhp_trend;
  bp_pkg::trend_t       ghp_trend;
  bp_pkg::stat_count_t  sp_stat_count;
  bp_pkg::stat_count_t  lhp_stat_count;
  bp_pkg::stat_count_t  ghp_stat_count;
  logic                 lookup_result;
  logic                 update_result;

  bp_request_stage i_request (
    .clk, .rst_n,
    .lookup_valid, .lookup_pc, .lookup_backward,
    .update_valid, .update_pc, .update_backward, .update_taken,
    .lk_valid, .lk_pc, .lk_backward,
    .up_valid, .up_pc, .up_backward, .up_taken,
    .ghr
  );

  // Word address bits above the byte offset select the entry.
  assign lk_local_index  = lk_pc[`BP_INDEX_WIDTH+1:2];
  assign lk_global_index = lk_pc[`BP_INDEX_WIDTH+1:2] ^ ghr;
  assign up_local_index  = up_pc[`BP_INDEX_WIDTH+1:2];
  assign up_global_index = up_pc[`BP_INDEX_WIDTH+1:2] ^ ghr;

  pattern_table local_table (
    .clk, .rst_n,
    .lookup_index(lk_local_index), .update_index(up_local_index),
    .train(up_valid), .taken(up_taken),
    .lookup_taken(lhp_lookup), .update_taken_guess(lhp_update)
  );

  pattern_table global_table (
    .clk, .rst_n,
    .lookup_index(lk_global_index), .update_index(up_global_index),
    .train(up_valid), .taken(up_taken),
    .lookup_taken(ghp_lookup), .update_taken_guess(ghp_update)
  );

  // The static guess is the backward bit itself.
  predictor_scoreboard sp_score (
    .clk, .rst_n, .record(up_valid), .hit(up_backward == up_taken),
    .trend(sp_trend), .stat_count(sp_stat_count)
  );

  predictor_scoreboard lhp_score (
    .clk, .rst_n, .record(up_valid), .hit(lhp_update == up_taken),
    .trend(lhp_trend), .stat_count(lhp_stat_count)
  );

  predictor_scoreboard ghp_score (
    .clk, .rst_n, .record(up_valid), .hit(ghp_update == up_taken),
    .trend(ghp_trend), .stat_count(ghp_stat_count)
  );

  prediction_arbiter arb_lookup (
    .sp_prediction(lk_backward), .lhp_prediction(lhp_lookup), .ghp_prediction(ghp_lookup),
    .sp_trend, .lhp_trend, .ghp_trend,
    .sp_stat_count, .lhp_stat_count, .ghp_stat_count,
    .prediction_result(lookup_result)
  );

  prediction_arbiter arb_update (
    .sp_prediction(up_backward), .lhp_prediction(lhp_update), .ghp_prediction(ghp_update),
    .sp_trend, .lhp_trend, .ghp_trend,
    .sp_stat_count, .lhp_stat_count, .ghp_stat_count,
    .prediction_result(update_result)
  );

  bp_result_stage i_result (
    .clk, .rst_n,
    .lk_valid, .lookup_result,
    .up_valid, .update_result, .up_taken,
    .pred_valid, .pred_taken, .miss_count
  );

endmodule

// File: verilog/bp_result_stage.sv
`timescale 1ns/1ns

module bp_result_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                lk_valid,
  input  logic                lookup_result,
  input  logic                up_valid,
  input  logic                update_result,
  input  logic                up_taken,
  output logic                pred_valid,
  output logic                pred_taken,
  output bp_pkg::miss_count_t miss_count
);

  localparam bp_pkg::miss_count_t MISS_MAX = '1;
  localparam bp_pkg::miss_count_t MISS_ONE = bp_pkg::miss_count_t'(1);

  logic mispredict;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pred_valid <= 1'b0;
      pred_taken <= 1'b0;
    end else begin
      pred_valid <= lk_valid;
      if (lk_valid) pred_taken <= lookup_result; // Holds between lookups.
    end
  end

  assign mispredict = up_valid && (update_result != up_taken);

  // Counts arbitrated mispredictions and sticks at the top.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      miss_count <= '0;
    end else if (mispredict && miss_count != MISS_MAX) begin
      miss_count <= miss_count + MISS_ONE;
    end
  end

endmodule

// File: verilog/prediction_arbiter.sv
`timescale 1ns/1ns
`include "bp_params.svh"

module prediction_arbiter (
  input  logic                sp_prediction,
  input  logic                lhp_prediction,
  input  logic                ghp_prediction,
  input  bp_pkg::trend_t      sp_trend,
  input  bp_pkg::trend_t      lhp_trend,
  input  bp_pkg::trend_t      ghp_trend,
  input  bp_pkg::stat_count_t sp_stat_count,
  input  bp_pkg::stat_count_t lhp_stat_count,
  input  bp_pkg::stat_count_t ghp_stat_count,
  output logic                prediction_result
);

  bp_pkg::stat_count_t sp_corrected;
  bp_pkg::stat_count_t lhp_corrected;
  bp_pkg::stat_count_t ghp_corrected;
  logic                sp_lhp_conflict;
  logic                sp_ghp_conflict;
  logic                no_conflict;
  logic                sp_only;
  logic                lhp_only;
  logic                ghp_only;
  bp_pkg::stat_count_t lone_count;
  bp_pkg::trend_t      lone_trend;
  logic                lone_guess;
  bp_pkg::stat_count_t pair_a;
  bp_pkg::stat_count_t pair_b;
  bp_pkg::stat_sum_t   pair_sum;
  bp_pkg::stat_sum_t   lone_sum;
  logic                lone_clean;
  logic                lone_wins;

  // A predictor that just missed carries no weight.
  assign sp_corrected  = sp_trend[0]  ? '0 : sp_stat_count;
  assign lhp_corrected = lhp_trend[0] ? '0 : lhp_stat_count;
  assign ghp_corrected = ghp_trend[0] ? '0 : ghp_stat_count;

  // With three one-bit guesses at most one can stand alone.
  assign sp_lhp_conflict = sp_prediction ^ lhp_prediction;
  assign sp_ghp_conflict = sp_prediction ^ ghp_prediction;
  assign no_conflict     = !sp_lhp_conflict && !sp_ghp_conflict;
  assign sp_only         = sp_lhp_conflict && sp_ghp_conflict;
  assign lhp_only        = sp_lhp_conflict && !sp_ghp_conflict;
  assign ghp_only        = !sp_lhp_conflict && sp_ghp_conflict;

  // One-hot pick of the lone predictor's count, trend and guess.
  assign lone_count = ({`BP_STAT_WIDTH{sp_only}}  & sp_corrected)
                    | ({`BP_STAT_WIDTH{lhp_only}} & lhp_corrected)
                    | ({`BP_STAT_WIDTH{ghp_only}} & ghp_corrected);
  assign lone_trend = ({`BP_TREND_WIDTH{sp_only}}  & sp_trend)
                    | ({`BP_TREND_WIDTH{lhp_only}} & lhp_trend)
                    | ({`BP_TREND_WIDTH{ghp_only}} & ghp_trend);
  assign lone_guess = (sp_only & sp_prediction)
                    | (lhp_only & lhp_prediction)
                    | (ghp_only & ghp_prediction);

  // The two agreeing predictors.
  assign pair_a   = sp_lhp_conflict ? ghp_corrected : sp_corrected;
  assign pair_b   = sp_ghp_conflict ? lhp_corrected : sp_corrected;
  assign pair_sum = bp_pkg::stat_sum_t'(pair_a) + bp_pkg::stat_sum_t'(pair_b);
  assign lone_sum = bp_pkg::stat_sum_t'(lone_count);

  // On a tie the lone guess needs no misses in the two oldest outcomes.
  assign lone_clean = !lone_trend[`BP_TREND_WIDTH-1] && !lone_trend[`BP_TREND_WIDTH-2];
  assign lone_wins  = (lone_sum > pair_sum) || (lone_sum == pair_sum && lone_clean);

  assign prediction_result = no_conflict ? sp_prediction :
                             lone_wins   ? lone_guess    : ~lone_guess;

endmodule

// File: verilog/predictor_scoreboard.sv
`timescale 1ns/1ns
`include "bp_params.svh"

module predictor_scoreboard (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                record,
  input  logic                hit,
  output bp_pkg::trend_t      trend,
  output bp_pkg::stat_count_t stat_count
);

  localparam bp_pkg::stat_count_t STAT_MAX = '1;
  localparam bp_pkg::stat_count_t STAT_ONE = bp_pkg::stat_count_t'(1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      trend <= '0;
    end else if (record) begin
      trend <= {trend[`BP_TREND_WIDTH-2:0], ~hit}; // A miss shifts in a 1.
    end
  end

  // Hit count rises on hits and falls on misses, held between 0 and the top.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stat_count <= '0;
    end else if (record) begin
      if (hit && stat_count != STAT_MAX) begin
        stat_count <= stat_count + STAT_ONE;
      end else if (!hit && stat_count != '0) begin
        stat_count <= stat_count - STAT_ONE;
      end
    end
  end

endmodule

// File: verilog/pattern_table.sv
`timescale 1ns/1ns
`include "bp_params.svh"

module pattern_table (
  input  logic                 clk,
  input  logic                 rst_n,
  input  bp_pkg::table_index_t lookup_index,
  input  bp_pkg::table_index_t update_index,
  input  logic                 train,
  input  logic                 taken,
  output logic                 lookup_taken,
  output logic                 update_taken_guess
);

  localparam int DEPTH = 1 << `BP_INDEX_WIDTH;

  bp_pkg::counter2_t counters [DEPTH];
  bp_pkg::counter2_t entry;

  assign entry = counters[update_index];

  // Saturating 2-bit counters, trained one entry at a time.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        counters[i] <= `BP_COUNTER_RESET;
      end
    end else if (train) begin
      if (taken && entry != 2'b11) begin
        counters[update_index] <= entry + 2'b01;
      end else if (!taken && entry != 2'b00) begin
        counters[update_index] <= entry - 2'b01;
      end
    end
  end

  // The MSB of a counter is its direction.
  assign lookup_taken       = counters[lookup_index][1];
  assign update_taken_guess = entry[1]; // Read before the write at the next edge.

endmodule

// File: verilog/bp_request_stage.sv
`timescale 1ns/1ns

module bp_request_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 lookup_valid,
  input  bp_pkg::pc_t          lookup_pc,
  input  logic                 lookup_backward,
  input  logic                 update_valid,
  input  bp_pkg::pc_t          update_pc,
  input  logic                 update_backward,
  input  logic                 update_taken,
  output logic                 lk_valid,
  output bp_pkg::pc_t          lk_pc,
  output logic                 lk_backward,
  output logic                 up_valid,
  output bp_pkg::pc_t          up_pc,
  output logic                 up_backward,
  output logic                 up_taken,
  output bp_pkg::table_index_t ghr
);

  // Request strobes.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lk_valid <= 1'b0;
      up_valid <= 1'b0;
    end else begin
      lk_valid <= lookup_valid;
      up_valid <= update_valid;
    end
  end

  // Lookup payload is only looked at while lk_valid is high.
  always_ff @(posedge clk) begin
    if (lookup_valid) begin
      lk_pc       <= lookup_pc;
      lk_backward <= lookup_backward;
    end
  end

  always_ff @(posedge clk) begin
    if (update_valid) begin
      up_pc       <= update_pc;
      up_backward <= update_backward;
      up_taken    <= update_taken;
    end
  end

  // The history moves one cycle after the update is registered, so the
  // indexes of that update and of any lookup beside it see the old value.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ghr <= '0;
    end else if (up_valid) begin
      ghr <= {ghr[$bits(ghr)-2:0], up_taken}; // Newest outcome in bit 0.
    end
  end

endmodule

// File: verilog/bp_pkg.sv
`include "bp_params.svh"

package bp_pkg;

  typedef logic [`BP_PC_WIDTH-1:0] pc_t;

  // Also carries the global history register.
  typedef logic [`BP_INDEX_WIDTH-1:0] table_index_t;

  typedef logic [1:0] counter2_t;

  typedef logic [`BP_STAT_WIDTH-1:0] stat_count_t;

  // One bit wider so that two hit counts add without overflow.
  typedef logic [`BP_STAT_WIDTH:0] stat_sum_t;

  // Bit 0 is the newest outcome, a 1 marks a miss.
  typedef logic [`BP_TREND_WIDTH-1:0] trend_t;

  typedef logic [`BP_MISS_COUNT_WIDTH-1:0] miss_count_t;

endpackage

// File: include/bp_params.svh
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// Width of a branch address.
`define BP_PC_WIDTH 32

// Table index width, also the length of the global history.
`define BP_INDEX_WIDTH 4

// Width of a scoreboard hit count.
`define BP_STAT_WIDTH 5

// Number of outcomes kept in a miss trend.
`define BP_TREND_WIDTH 4

`define BP_MISS_COUNT_WIDTH 16

// Every direction counter starts weakly not taken.
`define BP_COUNTER_RESET 2'b01

`endif
